/* flist.f */
logic/n64VideoPkg.sv
logic/n64OutputPkg.sv
logic/pixelIf.sv
logic/n64VideoDemux.sv
logic/pixelFifo.sv
logic/colorSpaceOut.sv
logic/n64VideoTop.sv
tb/n64VideoTb.sv

/* Makefile */
# Verilator build and run for the N64 video data path

TOP       ?= n64VideoTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: TOP FLIST OBJ_DIR LOG VERILATOR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/n64VideoTb.sv */
////////////////////////////////////////
// N64 video data path testbench
// Table of bus pixels with expected DAC
// words, checked in output order
////////////////////////////////////////

`default_nettype none

module n64VideoTb;
  import n64VideoPkg::*;
  import n64OutputPkg::*;

  // Mirrors the DUT default
  localparam int prefillLevel = 2;
  localparam int numDirected  = 12;
  localparam int numRandom    = 24;
  localparam int numEntries   = numDirected + numRandom;
  // First entry after the long stall
  localparam int stallIdx     = 9;

  typedef struct {
    logic [syncWidth-1:0]   sync;
    logic [colorWidthI-1:0] r;
    logic [colorWidthI-1:0] g;
    logic [colorWidthI-1:0] b;
    logic                   nEnRgsb;
    logic                   nEnYpbpr;
    int                     gap;
    // DAC word followed by nCsync nHsync and nVsync
    logic [26:0]            expected;
  } entryT;

  logic                   VCLK;
  logic                   reset_i;
  logic                   nVdsync_i;
  logic [colorWidthI-1:0] vd_i;
  logic                   nEnRgsb_i;
  logic                   nEnYpbpr_i;
  logic [23:0]            vd_o;
  logic                   nCsync_o;
  logic                   nHsync_o;
  logic                   nVsync_o;
  logic                   pixValid_o;
  logic                   underrun_o;

  entryT       stimTable [numEntries];
  logic [26:0] expQ [$];
  logic [26:0] expPix;
  logic [15:0] lfsrState;
  int          errorCount = 0;
  int          pushCount = 0;
  int          outCount = 0;
  int          cycleCount = 0;
  int          cycleLimit = 1000000;

  n64VideoTop u_dut (
    .VCLK       (VCLK),
    .reset_i    (reset_i),
    .nVdsync_i  (nVdsync_i),
    .vd_i       (vd_i),
    .nEnRgsb_i  (nEnRgsb_i),
    .nEnYpbpr_i (nEnYpbpr_i),
    .vd_o       (vd_o),
    .nCsync_o   (nCsync_o),
    .nHsync_o   (nHsync_o),
    .nVsync_o   (nVsync_o),
    .pixValid_o (pixValid_o),
    .underrun_o (underrun_o)
  );

  initial begin
    VCLK = 1'b0;
    forever #5 VCLK = ~VCLK;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic failRun();
    $display("Errors found");
    $fatal(1, "Stopping at first failure");
  endtask

  task automatic checkValue(input string name, input logic [23:0] actual,
                            input logic [23:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      failRun();
    end
  endtask

  // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [15:0] takeBits(input int n);
    logic [15:0] value;
    int          k;
    value = '0;
    for (k = 0; k < n; k++) begin
      lfsrState = {lfsrState[14:0],
                   lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
      value = {value[14:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic logic [7:0] clampToByte(input int v);
    if (v < 0) begin
      return 8'd0;
    end
    if (v > 255) begin
      return 8'd255;
    end
    return 8'(v);
  endfunction

  // Reference conversion where sync bits 0 1 3 are csync hsync vsync
  function automatic logic [26:0] modelPixel(input entryT e);
    int          rx;
    int          gx;
    int          bx;
    int          y;
    logic [23:0] word;
    rx = {e.r, e.r[6]};
    gx = {e.g, e.g[6]};
    bx = {e.b, e.b[6]};
    if (!e.nEnYpbpr) begin
      y = (77 * rx + 150 * gx + 29 * bx) >>> 8;
      if (!e.sync[0]) begin
        y = 0;
      end
      word = {8'(y), clampToByte(128 + ((128 * bx - 43 * rx - 85 * gx) >>> 8)),
              clampToByte(128 + ((128 * rx - 107 * gx - 21 * bx) >>> 8))};
    end else if (!e.nEnRgsb) begin
      word = {8'(rx), e.sync[0] ? 8'(gx) : 8'd0, 8'(bx)};
    end else begin
      word = {8'(rx), 8'(gx), 8'(bx)};
    end
    return {word, e.sync[0], e.sync[1], e.sync[3]};
  endfunction

  task automatic setEntry(input int idx, input logic [3:0] sync, input logic [6:0] r,
                          input logic [6:0] g, input logic [6:0] b, input logic nRgsb,
                          input logic nYpbpr, input int gap);
    stimTable[idx].sync     = sync;
    stimTable[idx].r        = r;
    stimTable[idx].g        = g;
    stimTable[idx].b        = b;
    stimTable[idx].nEnRgsb  = nRgsb;
    stimTable[idx].nEnYpbpr = nYpbpr;
    stimTable[idx].gap      = gap;
  endtask

  task automatic buildTable();
    int i;
    // RGB and then RGsB with a stray sequence after the last one
    setEntry(0, 4'hF, 7'h00, 7'h7F, 7'h40, 1'b1, 1'b1, 0);
    setEntry(1, 4'hF, 7'h12, 7'h34, 7'h56, 1'b1, 1'b1, 0);
    setEntry(2, 4'hC, 7'h7F, 7'h7F, 7'h7F, 1'b1, 1'b1, 0);
    setEntry(3, 4'hF, 7'h33, 7'h66, 7'h11, 1'b0, 1'b1, 0);
    setEntry(4, 4'hC, 7'h21, 7'h7F, 7'h05, 1'b0, 1'b1, 0);
    setEntry(5, 4'h6, 7'h7F, 7'h40, 7'h3F, 1'b0, 1'b1, 4);
    // YPbPr overrides RGsB and the long gap drains the FIFO
    setEntry(6, 4'hF, 7'h7F, 7'h7F, 7'h7F, 1'b0, 1'b0, 0);
    setEntry(7, 4'hF, 7'h00, 7'h00, 7'h00, 1'b1, 1'b0, 0);
    setEntry(8, 4'hE, 7'h7F, 7'h00, 7'h00, 1'b1, 1'b0, 40);
    setEntry(9, 4'hF, 7'h01, 7'h02, 7'h03, 1'b1, 1'b1, 0);
    setEntry(10, 4'hD, 7'h70, 7'h0F, 7'h55, 1'b1, 1'b1, 0);
    setEntry(11, 4'h4, 7'h2A, 7'h7E, 7'h01, 1'b0, 1'b1, 0);
    // Random colours with the first half all YPbPr
    for (i = numDirected; i < numEntries; i++) begin
      setEntry(i, 4'(takeBits(4)), 7'(takeBits(7)), 7'(takeBits(7)), 7'(takeBits(7)),
               1'(takeBits(1)), (i < numDirected + numRandom / 2) ? 1'b0 : 1'(takeBits(1)), 0);
    end
    stimTable[numDirected].g     = 7'h7F;
    stimTable[numDirected + 1].r = 7'h00;
    for (i = 0; i < numEntries; i++) begin
      stimTable[i].expected = modelPixel(stimTable[i]);
    end
  endtask

  // Sync word and three colour words followed by idle words that form no pixel
  task automatic sendPixel(input int idx);
    int k;
    @(negedge VCLK);
    nVdsync_i  = 1'b0;
    vd_i       = {3'b000, stimTable[idx].sync};
    nEnRgsb_i  = stimTable[idx].nEnRgsb;
    nEnYpbpr_i = stimTable[idx].nEnYpbpr;
    @(negedge VCLK);
    nVdsync_i  = 1'b1;
    vd_i       = stimTable[idx].r;
    // Jumpers flip after the sync word and must not reach this pixel
    nEnRgsb_i  = ~stimTable[idx].nEnRgsb;
    nEnYpbpr_i = ~stimTable[idx].nEnYpbpr;
    @(negedge VCLK);
    vd_i = stimTable[idx].g;
    @(negedge VCLK);
    vd_i = stimTable[idx].b;
    expQ.push_back(stimTable[idx].expected);
    pushCount++;
    for (k = 0; k < stimTable[idx].gap; k++) begin
      @(negedge VCLK);
      vd_i = 7'(takeBits(7));
    end
  endtask

  ////////////////////////////////////////
  // Monitor and timeout
  ////////////////////////////////////////

  always @(negedge VCLK) begin
    if (!reset_i && pixValid_o) begin
      if (expQ.size() == 0) begin
        $display("An output pixel appeared when no pixel was expected");
        failRun();
      end else begin
        expPix = expQ.pop_front();
        if (outCount == stallIdx) begin
          // The last refill pixel needs more than a pixel period to reach the output
          if (pushCount - stallIdx <= prefillLevel) begin
            $display("Output resumed after the stall before the FIFO was refilled");
            failRun();
          end
          checkValue("underrun_o", 24'(underrun_o), 24'd1);
        end
        checkValue("vd_o", vd_o, expPix[26:3]);
        checkValue("nCsync_o", 24'(nCsync_o), 24'(expPix[2]));
        checkValue("nHsync_o", 24'(nHsync_o), 24'(expPix[1]));
        checkValue("nVsync_o", 24'(nVsync_o), 24'(expPix[0]));
        outCount++;
      end
    end
  end

  always @(posedge VCLK) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      failRun();
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    reset_i    = 1'b1;
    nVdsync_i  = 1'b1;
    vd_i       = '0;
    nEnRgsb_i  = 1'b1;
    nEnYpbpr_i = 1'b1;
    lfsrState  = 16'd14123;
    buildTable();
    // Limit covers reset, all bus words and gaps, prefill lead and drain margin
    cycleLimit = 16 + 4 * numEntries + 4 * prefillLevel + 64 + 3 * pixelPeriod;
    for (int i = 0; i < numEntries; i++) begin
      cycleLimit += stimTable[i].gap;
    end
    repeat (16) @(negedge VCLK);
    reset_i = 1'b0;
    checkValue("vd_o", vd_o, 24'd0);
    checkValue("nCsync_o", 24'(nCsync_o), 24'd1);
    checkValue("pixValid_o", 24'(pixValid_o), 24'd0);
    checkValue("underrun_o", 24'(underrun_o), 24'd0);
    for (int i = 0; i < numEntries; i++) begin
      sendPixel(i);
    end
    @(negedge VCLK);
    vd_i = '0;
    while (expQ.size() != 0) begin
      @(negedge VCLK);
    end
    // No late pixel may follow and underrun stays set
    repeat (3 * pixelPeriod) @(negedge VCLK);
    checkValue("underrun_o", 24'(underrun_o), 24'd1);
    if (errorCount == 0) begin
      $display("No errors");
      $finish;
    end else begin
      failRun();
    end
  end

endmodule

`default_nettype wire

/* logic/n64VideoTop.sv */
////////////////////////////////////////
// N64 video data path top
// Demux, elastic FIFO and colour space
// converter between bus and video DAC
////////////////////////////////////////

`default_nettype none

module n64VideoTop #(
  parameter int fifoAddrWidth = 3,
  parameter int prefillLevel  = 2
) (
  // N64 video bus
  input  wire                                     VCLK,
  input  wire                                     reset_i,
  input  wire                                     nVdsync_i,
  input  wire [n64VideoPkg::colorWidthI-1:0]      vd_i,

  // Mode jumpers, active low
  input  wire                                     nEnRgsb_i,
  input  wire                                     nEnYpbpr_i,

  // Video DAC side
  output logic [3*n64OutputPkg::colorWidthO-1:0]  vd_o,
  output logic                                    nCsync_o,
  output logic                                    nHsync_o,
  output logic                                    nVsync_o,
  output logic                                    pixValid_o,
  output logic                                    underrun_o
);

  pixelIf wrPix ();
  pixelIf rdPix ();

  logic popReq;
  logic primed;

  // Bus words to pixel strobes
  n64VideoDemux u_demux (
    .VCLK       (VCLK),
    .reset_i    (reset_i),
    .nVdsync_i  (nVdsync_i),
    .vd_i       (vd_i),
    .nEnRgsb_i  (nEnRgsb_i),
    .nEnYpbpr_i (nEnYpbpr_i),
    .pixOut     (wrPix)
  );

  // Absorbs the gap between bus timing and output pacing
  pixelFifo #(
    .fifoAddrWidth (fifoAddrWidth),
    .prefillLevel  (prefillLevel)
  ) u_fifo (
    .VCLK       (VCLK),
    .reset_i    (reset_i),
    .pixIn      (wrPix),
    .popReq_i   (popReq),
    .primed_o   (primed),
    .underrun_o (underrun_o),
    .pixOut     (rdPix)
  );

  colorSpaceOut u_convert (
    .VCLK       (VCLK),
    .reset_i    (reset_i),
    .primed_i   (primed),
    .popReq_o   (popReq),
    .pixIn      (rdPix),
    .vd_o       (vd_o),
    .nCsync_o   (nCsync_o),
    .nHsync_o   (nHsync_o),
    .nVsync_o   (nVsync_o),
    .pixValid_o (pixValid_o)
  );

endmodule

`default_nettype wire

/* logic/colorSpaceOut.sv */
////////////////////////////////////////
// Output pacing and colour conversion
// Pops one pixel per pixel period and
// forms RGB, RGsB or YPbPr for the DAC
////////////////////////////////////////

`default_nettype none

module colorSpaceOut (
  input  wire                    VCLK,
  input  wire                    reset_i,
  input  wire                    primed_i,
  output logic                   popReq_o,
  pixelIf.sink                   pixIn,
  output n64OutputPkg::compWordT vd_o,
  output logic                   nCsync_o,
  output logic                   nHsync_o,
  output logic                   nVsync_o,
  output logic                   pixValid_o
);
  import n64VideoPkg::*;
  import n64OutputPkg::*;

  localparam int prodWidth = 2 * colorWidthO;
  localparam int sumWidth  = prodWidth + 2;
  localparam int paceWidth = $clog2(pixelPeriod);

  logic [paceWidth-1:0]         paceCnt;
  outModeT                      pixMode;
  logic                         s1Valid;
  outModeT                      s1Mode;
  logic [syncWidth-1:0]         s1Sync;
  logic [colorWidthO-1:0]       s1R;
  logic [colorWidthO-1:0]       s1G;
  logic [colorWidthO-1:0]       s1B;
  logic [prodWidth-1:0]         prodY [3];
  logic [prodWidth-1:0]         prodPb [3];
  logic [prodWidth-1:0]         prodPr [3];
  logic [sumWidth-1:0]          ySum;
  logic signed [sumWidth-1:0]   pbSum;
  logic signed [sumWidth-1:0]   prSum;
  logic signed [sumWidth-1:0]   pbFull;
  logic signed [sumWidth-1:0]   prFull;
  compWordT                     nextWord;

  // 7-bit colour to 8 bits by repeating the top bit
  function automatic logic [colorWidthO-1:0] expand(input logic [colorWidthI-1:0] c);
    return {c, c[colorWidthI-1]};
  endfunction

  function automatic logic [prodWidth-1:0] mul8(input logic [colorWidthO-1:0] a,
                                                input logic [colorWidthO-1:0] b);
    return {{colorWidthO{1'b0}}, a} * {{colorWidthO{1'b0}}, b};
  endfunction

  function automatic logic [colorWidthO-1:0] clampByte(input logic signed [sumWidth-1:0] v);
    logic [colorWidthO-1:0] result;
    if (v < 0) begin
      result = '0;
    end else if (v > sumWidth'(255)) begin
      result = '1;
    end else begin
      result = v[colorWidthO-1:0];
    end
    return result;
  endfunction

  ////////////////////////////////////////
  // Read pacing
  ////////////////////////////////////////

  // First pop right after primed, then one per pixel period
  always_ff @(posedge VCLK) begin
    if (reset_i || !primed_i) begin
      paceCnt  <= '0;
      popReq_o <= 1'b0;
    end else begin
      popReq_o <= (paceCnt == '0);
      paceCnt  <= (paceCnt == paceWidth'(pixelPeriod - 1)) ? '0 : paceCnt + 1'b1;
    end
  end

  // YPbPr jumper overrides RGsB
  always_comb begin
    if (!pixIn.mode[jumperBitYpbpr]) begin
      pixMode = modeYpbpr;
    end else if (!pixIn.mode[jumperBitRgsb]) begin
      pixMode = modeRgsb;
    end else begin
      pixMode = modeRgb;
    end
  end

  ////////////////////////////////////////
  // Stage 1 products
  ////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    s1Sync    <= pixIn.sync;
    s1Mode    <= pixMode;
    s1R       <= expand(pixIn.r);
    s1G       <= expand(pixIn.g);
    s1B       <= expand(pixIn.b);
    prodY[0]  <= mul8(coefYr, expand(pixIn.r));
    prodY[1]  <= mul8(coefYg, expand(pixIn.g));
    prodY[2]  <= mul8(coefYb, expand(pixIn.b));
    prodPb[0] <= mul8(coefPbR, expand(pixIn.r));
    prodPb[1] <= mul8(coefPbG, expand(pixIn.g));
    prodPb[2] <= mul8(coefPbB, expand(pixIn.b));
    prodPr[0] <= mul8(coefPrR, expand(pixIn.r));
    prodPr[1] <= mul8(coefPrG, expand(pixIn.g));
    prodPr[2] <= mul8(coefPrB, expand(pixIn.b));
  end

  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= pixIn.valid;
    end
  end

  ////////////////////////////////////////
  // Stage 2 sums, clamp and select
  ////////////////////////////////////////

  always_comb begin
    // Luma peaks at 255*256 so bits 15:8 hold the floored result
    ySum   = {2'b00, prodY[0]} + {2'b00, prodY[1]} + {2'b00, prodY[2]};
    pbSum  = $signed({2'b00, prodPb[2]}) - $signed({2'b00, prodPb[0]})
           - $signed({2'b00, prodPb[1]});
    prSum  = $signed({2'b00, prodPr[0]}) - $signed({2'b00, prodPr[1]})
           - $signed({2'b00, prodPr[2]});
    // Arithmetic shift floors toward minus infinity
    pbFull = sumWidth'(128) + (pbSum >>> colorWidthO);
    prFull = sumWidth'(128) + (prSum >>> colorWidthO);
  end

  always_comb begin
    nextWord = '0;
    case (s1Mode)
      modeYpbpr: begin
        // Blank luma during composite sync
        nextWord.ypbpr.y  = s1Sync[syncBitCsync] ? ySum[prodWidth-1:colorWidthO] : '0;
        nextWord.ypbpr.pb = clampByte(pbFull);
        nextWord.ypbpr.pr = clampByte(prFull);
      end
      modeRgsb: begin
        nextWord.rgb.r = s1R;
        nextWord.rgb.g = s1Sync[syncBitCsync] ? s1G : '0;
        nextWord.rgb.b = s1B;
      end
      default: begin
        nextWord.rgb.r = s1R;
        nextWord.rgb.g = s1G;
        nextWord.rgb.b = s1B;
      end
    endcase
  end

  // Outputs hold the last pixel between strobes
  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      vd_o       <= '0;
      nCsync_o   <= 1'b1;
      nHsync_o   <= 1'b1;
      nVsync_o   <= 1'b1;
      pixValid_o <= 1'b0;
    end else begin
      pixValid_o <= s1Valid;
      if (s1Valid) begin
        vd_o     <= nextWord;
        nCsync_o <= s1Sync[syncBitCsync];
        nHsync_o <= s1Sync[syncBitHsync];
        nVsync_o <= s1Sync[syncBitVsync];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/pixelFifo.sv */
////////////////////////////////////////
// Elastic pixel buffer
// Prefill flag with hysteresis and sticky
// underrun detection
////////////////////////////////////////

`default_nettype none

module pixelFifo #(
  parameter int fifoAddrWidth = 3,
  parameter int prefillLevel  = 2
) (
  input  wire    VCLK,
  input  wire    reset_i,
  pixelIf.sink   pixIn,
  input  wire    popReq_i,
  output logic   primed_o,
  output logic   underrun_o,
  pixelIf.source pixOut
);
  import n64VideoPkg::*;

  localparam int fifoDepth = 1 << fifoAddrWidth;
  localparam logic [fifoAddrWidth:0] primeCount = (fifoAddrWidth + 1)'(prefillLevel);

  pixelT                    mem [fifoDepth];
  pixelT                    wrWord;
  pixelT                    rdWord;
  logic [fifoAddrWidth-1:0] wrPtr;
  logic [fifoAddrWidth-1:0] rdPtr;
  logic [fifoAddrWidth:0]   count;
  logic                     empty;
  logic                     doPop;
  logic                     emptyPop;
  logic                     rdValid;

  assign wrWord = '{sync: pixIn.sync, r: pixIn.r, g: pixIn.g, b: pixIn.b, mode: pixIn.mode};

  // Input rate is at most one pixel per four cycles so no overflow check
  assign empty    = (count == '0);
  assign doPop    = popReq_i && !empty;
  assign emptyPop = popReq_i && empty;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (pixIn.valid) begin
      mem[wrPtr] <= wrWord;
    end
    if (doPop) begin
      rdWord <= mem[rdPtr];
    end
  end

  ////////////////////////////////////////
  // Pointers, level and status
  ////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      count      <= '0;
      rdValid    <= 1'b0;
      primed_o   <= 1'b0;
      underrun_o <= 1'b0;
    end else begin
      if (pixIn.valid) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      count   <= count + {{fifoAddrWidth{1'b0}}, pixIn.valid}
                       - {{fifoAddrWidth{1'b0}}, doPop};
      // Pop answered one cycle later, an empty pop gives nothing
      rdValid <= doPop;
      // Only an empty pop drops primed, so a restart always has the same lead
      if (emptyPop) begin
        primed_o   <= 1'b0;
        underrun_o <= 1'b1;
      end else if (count >= primeCount) begin
        primed_o <= 1'b1;
      end
    end
  end

  assign pixOut.valid = rdValid;
  assign pixOut.sync  = rdWord.sync;
  assign pixOut.r     = rdWord.r;
  assign pixOut.g     = rdWord.g;
  assign pixOut.b     = rdWord.b;
  assign pixOut.mode  = rdWord.mode;

endmodule

`default_nettype wire

/* logic/n64VideoDemux.sv */
////////////////////////////////////////
// N64 video bus demultiplexer
// Collects sync, red, green and blue words
// into one pixel strobe
////////////////////////////////////////

`default_nettype none

module n64VideoDemux (
  input  wire                                 VCLK,
  input  wire                                 reset_i,
  input  wire                                 nVdsync_i,
  input  wire [n64VideoPkg::colorWidthI-1:0]  vd_i,
  input  wire                                 nEnRgsb_i,
  input  wire                                 nEnYpbpr_i,
  pixelIf.source                              pixOut
);
  import n64VideoPkg::*;

  // Which colour word the bus carries next
  localparam logic [1:0] phaseIdle  = 2'd0;
  localparam logic [1:0] phaseRed   = 2'd1;
  localparam logic [1:0] phaseGreen = 2'd2;
  localparam logic [1:0] phaseBlue  = 2'd3;

  logic [1:0] phase;
  logic       validReg;
  pixelT      pixReg;

  ////////////////////////////////////////
  // Word sequencing
  ////////////////////////////////////////

  // A sync word always restarts the sequence
  // Words after blue wait in idle for the next sync word
  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      phase    <= phaseIdle;
      validReg <= 1'b0;
    end else begin
      validReg <= 1'b0;
      if (!nVdsync_i) begin
        phase <= phaseRed;
      end else begin
        case (phase)
          phaseRed:   phase <= phaseGreen;
          phaseGreen: phase <= phaseBlue;
          phaseBlue: begin
            // Pixel complete, strobe in the next cycle
            phase    <= phaseIdle;
            validReg <= 1'b1;
          end
          default: phase <= phaseIdle;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Field capture
  ////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (!nVdsync_i) begin
      pixReg.sync <= vd_i[syncWidth-1:0];
      // Jumpers are taken only here so a pixel never mixes modes
      pixReg.mode[jumperBitRgsb]  <= nEnRgsb_i;
      pixReg.mode[jumperBitYpbpr] <= nEnYpbpr_i;
    end else begin
      case (phase)
        phaseRed:   pixReg.r <= vd_i;
        phaseGreen: pixReg.g <= vd_i;
        phaseBlue:  pixReg.b <= vd_i;
        default: ;
      endcase
    end
  end

  // Fields hold until the next sync word, so they are stable under valid
  assign pixOut.valid = validReg;
  assign pixOut.sync  = pixReg.sync;
  assign pixOut.r     = pixReg.r;
  assign pixOut.g     = pixReg.g;
  assign pixOut.b     = pixReg.b;
  assign pixOut.mode  = pixReg.mode;

endmodule

`default_nettype wire

/* logic/pixelIf.sv */
////////////////////////////////////////
// Pixel strobe interface
// One-cycle valid with sync, colour and
// raw mode fields, no back-pressure
////////////////////////////////////////

`default_nettype none

interface pixelIf;
  import n64VideoPkg::*;

  // Strobe for one pixel, fields valid in the same cycle
  logic                   valid;
  // Active-low sync nibble of this pixel
  logic [syncWidth-1:0]   sync;
  logic [colorWidthI-1:0] r;
  logic [colorWidthI-1:0] g;
  logic [colorWidthI-1:0] b;
  // Raw jumpers latched with the sync word
  logic [jumperWidth-1:0] mode;

  // Side that produces pixels
  modport source (output valid, sync, r, g, b, mode);

  // Side that takes pixels
  modport sink (input valid, sync, r, g, b, mode);

endinterface

`default_nettype wire

/* logic/n64OutputPkg.sv */
////////////////////////////////////////
// Video DAC output definitions
// Output modes, component word and
// YPbPr conversion coefficients
////////////////////////////////////////

`default_nettype none

package n64OutputPkg;

  // One DAC component
  localparam int colorWidthO = 8;

  // VCLK cycles per pixel on the N64 bus
  localparam int pixelPeriod = 4;

  typedef enum logic [1:0] {
    modeRgb,
    modeRgsb,
    modeYpbpr
  } outModeT;

  ////////////////////////////////////////
  // Component word seen as RGB or YPbPr
  ////////////////////////////////////////

  typedef struct packed {
    logic [colorWidthO-1:0] r;
    logic [colorWidthO-1:0] g;
    logic [colorWidthO-1:0] b;
  } rgbWordT;

  typedef struct packed {
    logic [colorWidthO-1:0] y;
    logic [colorWidthO-1:0] pb;
    logic [colorWidthO-1:0] pr;
  } ypbprWordT;

  typedef union packed {
    rgbWordT   rgb;
    ypbprWordT ypbpr;
  } compWordT;

  // Luma weights, all added
  localparam logic [colorWidthO-1:0] coefYr  = 8'd77;
  localparam logic [colorWidthO-1:0] coefYg  = 8'd150;
  localparam logic [colorWidthO-1:0] coefYb  = 8'd29;
  // Pb magnitudes, red and green subtracted
  localparam logic [colorWidthO-1:0] coefPbR = 8'd43;
  localparam logic [colorWidthO-1:0] coefPbG = 8'd85;
  localparam logic [colorWidthO-1:0] coefPbB = 8'd128;
  // Pr magnitudes, green and blue subtracted
  localparam logic [colorWidthO-1:0] coefPrR = 8'd128;
  localparam logic [colorWidthO-1:0] coefPrG = 8'd107;
  localparam logic [colorWidthO-1:0] coefPrB = 8'd21;

endpackage

`default_nettype wire

/* logic/n64VideoPkg.sv */
////////////////////////////////////////
// N64 video input definitions
// Bus word widths, sync nibble layout and
// the pixel word collected from the bus
////////////////////////////////////////

`default_nettype none

package n64VideoPkg;

  // One colour word on the N64 video bus
  localparam int colorWidthI = 7;

  // Sync word carries four active-low bits in its low nibble
  localparam int syncWidth = 4;

  // Bit positions inside the sync nibble
  localparam int syncBitCsync = 0;
  localparam int syncBitHsync = 1;
  localparam int syncBitClamp = 2;
  localparam int syncBitVsync = 3;

  // Raw mode jumpers as latched with each pixel
  localparam int jumperWidth = 2;

  // Jumper positions in the latched mode field (both active low)
  localparam int jumperBitRgsb  = 0;
  localparam int jumperBitYpbpr = 1;

  ////////////////////////////////////////
  // Collected pixel
  ////////////////////////////////////////

  // One complete pixel as stored in the FIFO
  // 4 + 3*7 + 2 = 27 bits
  typedef struct packed {
    logic [syncWidth-1:0]   sync;
    logic [colorWidthI-1:0] r;
    logic [colorWidthI-1:0] g;
    logic [colorWidthI-1:0] b;
    logic [jumperWidth-1:0] mode;
  } pixelT;

endpackage

`default_nettype wire
